// File: rtl/pmp_pkg.sv
// shared PMP types; the address map is 32 bits with word granularity and no lock support
package pmp_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // address widths
   ////////////////////////////////////////////////////////////////////////////

   // full byte address as seen on the data port
   typedef logic [31:0] addr_t;

   // byte address without its two low bits
   typedef logic [29:0] word_addr_t;

   // first byte address bit that is part of the word address
   localparam int unsigned word_lsb = $bits(addr_t) - $bits(word_addr_t);

   ////////////////////////////////////////////////////////////////////////////
   // privilege and matching modes
   ////////////////////////////////////////////////////////////////////////////

   typedef enum logic [1:0]
   {
      priv_u = 2'd0,
      priv_s = 2'd1,
      priv_m = 2'd3
   } priv_lvl_e;

   typedef enum logic [1:0]
   {
      mode_off   = 2'd0,
      mode_tor   = 2'd1,
      mode_na4   = 2'd2,
      mode_napot = 2'd3
   } pmp_mode_e;

   ////////////////////////////////////////////////////////////////////////////
   // configuration byte and decoded region
   ////////////////////////////////////////////////////////////////////////////

   // field order follows the pmpcfg byte from the top bit down
   typedef struct packed
   {
      logic       lock;
      logic [1:0] reserved;
      pmp_mode_e  mode;
      logic       x;
      logic       w;
      logic       r;
   } pmp_cfg_t;

   // one rule after decode, bounds are word addresses
   typedef struct packed
   {
      logic       enable;
      pmp_mode_e  mode;
      logic       r;
      logic       w;
      logic       x;
      word_addr_t lo;
      word_addr_t hi;
      word_addr_t mask;
   } pmp_region_t;

endpackage

// File: rtl/pmp_rule_decode.sv
// combinational rule decode; rule words use only their low 30 bits and the lock bit is ignored
`timescale 1ns/1ps

module pmp_rule_decode
#(
   parameter int unsigned n_entries      = 16,
   parameter int unsigned napot_max_ones = 16
)
(
   input  pmp_pkg::pmp_cfg_t    [n_entries-1:0] pmp_cfg_i,
   input  pmp_pkg::addr_t       [n_entries-1:0] pmp_addr_i,
   output pmp_pkg::pmp_region_t [n_entries-1:0] region_o
);

   // run of ones from bit 0 upward picks the NAPOT size
   function automatic int unsigned trailing_ones(pmp_pkg::word_addr_t word);
      int unsigned count;
      logic        run;
      count = 0;
      run   = 1'b1;
      for (int b = 0; b < $bits(pmp_pkg::word_addr_t); b++)
      begin
         run = run & word[b];
         if (run)
         begin
            count++;
         end
      end
      return count;
   endfunction

   pmp_pkg::word_addr_t [n_entries-1:0] rule_word;
   pmp_pkg::word_addr_t [n_entries-1:0] prev_word;

   ////////////////////////////////////////////////////////////////////////////
   // per entry decode
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < n_entries; i++)
   begin : g_entry
      int unsigned          ones;
      pmp_pkg::word_addr_t  napot_mask;
      pmp_pkg::pmp_region_t region;

      assign rule_word[i] = pmp_pkg::word_addr_t'(pmp_addr_i[i]);

      // TOR lower bound comes from the entry below and is zero for entry 0
      if (i == 0)
      begin : g_first
         assign prev_word[i] = '0;
      end
      else
      begin : g_next
         assign prev_word[i] = rule_word[i-1];
      end

      assign ones       = trailing_ones(rule_word[i]);
      assign napot_mask = {$bits(pmp_pkg::word_addr_t){1'b1}} << (ones + 1);

      always_comb
      begin
         region      = '0;
         region.mode = pmp_cfg_i[i].mode;
         region.r    = pmp_cfg_i[i].r;
         region.w    = pmp_cfg_i[i].w;
         region.x    = pmp_cfg_i[i].x;
         region.mask = '1;
         case (pmp_cfg_i[i].mode)
            pmp_pkg::mode_tor:
            begin
               region.enable = 1'b1;
               region.lo     = prev_word[i];
               region.hi     = rule_word[i];
            end
            pmp_pkg::mode_na4:
            begin
               region.enable = 1'b1;
               region.lo     = rule_word[i];
               region.hi     = rule_word[i];
            end
            pmp_pkg::mode_napot:
            begin
               // sizes beyond the configured limit stay disabled
               if (ones < napot_max_ones)
               begin
                  region.enable = 1'b1;
                  region.mask   = napot_mask;
                  region.lo     = rule_word[i] & napot_mask;
                  region.hi     = rule_word[i] | ~napot_mask;
               end
            end
            default:
            begin
               region.enable = 1'b0;
            end
         endcase
      end

      assign region_o[i] = region;
   end

endmodule

// File: rtl/pmp_region_match.sv
// combinational match of one data access against all regions; the x bit is never checked here
`timescale 1ns/1ps

module pmp_region_match
#(
   parameter int unsigned n_entries = 16
)
(
   input  pmp_pkg::pmp_region_t [n_entries-1:0] region_i,
   input  pmp_pkg::word_addr_t                  addr_i,
   input  logic                                 we_i,
   output logic                                 access_ok_o
);

   // region allows this kind of access
   logic [n_entries-1:0] perm_ok;
   // access address lies inside the region
   logic [n_entries-1:0] addr_hit;

   ////////////////////////////////////////////////////////////////////////////
   // per region checks
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      for (int e = 0; e < n_entries; e++)
      begin
         if (we_i)
         begin
            perm_ok[e] = region_i[e].enable & region_i[e].w;
         end
         else
         begin
            perm_ok[e] = region_i[e].enable & region_i[e].r;
         end

         case (region_i[e].mode)
            pmp_pkg::mode_tor:
            begin
               // upper bound is exclusive
               addr_hit[e] = (addr_i >= region_i[e].lo) && (addr_i < region_i[e].hi);
            end
            pmp_pkg::mode_na4:
            begin
               addr_hit[e] = (addr_i == region_i[e].lo);
            end
            pmp_pkg::mode_napot:
            begin
               addr_hit[e] = ((addr_i & region_i[e].mask) == region_i[e].lo);
            end
            default:
            begin
               addr_hit[e] = 1'b0;
            end
         endcase
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // any region is enough
   ////////////////////////////////////////////////////////////////////////////

   // no priority between entries, the first match does not win over a later one
   assign access_ok_o = |(perm_ok & addr_hit);

endmodule

// File: rtl/pmp_data_gate.sv
// gating is combinational; one error is held until acked and later denials are dropped
`timescale 1ns/1ps

module pmp_data_gate
(
   input  logic                clk,
   input  logic                rst_n,
   input  pmp_pkg::priv_lvl_e  priv_i,
   input  logic                access_ok_i,
   input  logic                data_req_i,
   input  logic                data_gnt_i,
   input  logic                data_err_ack_i,
   output logic                data_req_o,
   output logic                data_gnt_o,
   output logic                data_err_o
);

   typedef enum logic
   {
      err_idle,
      err_pending
   } err_state_e;

   err_state_e err_state_q;
   err_state_e err_state_d;
   logic       pass;
   logic       deny;

   ////////////////////////////////////////////////////////////////////////////
   // gating
   ////////////////////////////////////////////////////////////////////////////

   // machine mode bypasses the table
   assign pass = (priv_i == pmp_pkg::priv_m) | access_ok_i;

   assign data_req_o = data_req_i & pass;
   assign data_gnt_o = data_gnt_i & pass;
   assign deny       = data_req_i & ~pass;

   ////////////////////////////////////////////////////////////////////////////
   // error FSM
   ////////////////////////////////////////////////////////////////////////////

   always_comb
   begin
      err_state_d = err_state_q;
      case (err_state_q)
         err_idle:
         begin
            if (deny)
            begin
               err_state_d = err_pending;
            end
         end
         err_pending:
         begin
            if (data_err_ack_i)
            begin
               err_state_d = err_idle;
            end
         end
         default:
         begin
            err_state_d = err_idle;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         err_state_q <= err_idle;
      end
      else
      begin
         err_state_q <= err_state_d;
      end
   end

   assign data_err_o = (err_state_q == err_pending);

   // the error level only drops after an acknowledge
   a_err_clear_on_ack: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(data_err_o) |-> $past(data_err_ack_i));

endmodule

// File: rtl/pmp_top.sv
// data side PMP only; decode, match and gating add no cycles, the address is passed unchanged
`timescale 1ns/1ps

module pmp_top
#(
   parameter int unsigned n_entries      = 16,
   parameter int unsigned napot_max_ones = 16
)
(
   input  logic                              clk,
   input  logic                              rst_n,
   input  pmp_pkg::priv_lvl_e                priv_i,
   input  pmp_pkg::pmp_cfg_t [n_entries-1:0] pmp_cfg_i,
   input  pmp_pkg::addr_t    [n_entries-1:0] pmp_addr_i,

   // pipeline side
   input  logic                              data_req_i,
   input  pmp_pkg::addr_t                    data_addr_i,
   input  logic                              data_we_i,
   output logic                              data_gnt_o,

   // memory side
   output logic                              data_req_o,
   output pmp_pkg::addr_t                    data_addr_o,
   input  logic                              data_gnt_i,
   output logic                              data_err_o,
   input  logic                              data_err_ack_i
);

   pmp_pkg::pmp_region_t [n_entries-1:0] region;
   logic                                 access_ok;

   pmp_rule_decode #(
      .n_entries      (n_entries),
      .napot_max_ones (napot_max_ones)
   ) i_rule_decode (
      .pmp_cfg_i  (pmp_cfg_i),
      .pmp_addr_i (pmp_addr_i),
      .region_o   (region)
   );

   pmp_region_match #(
      .n_entries (n_entries)
   ) i_region_match (
      .region_i    (region),
      .addr_i      (data_addr_i[$bits(pmp_pkg::addr_t)-1:pmp_pkg::word_lsb]),
      .we_i        (data_we_i),
      .access_ok_o (access_ok)
   );

   pmp_data_gate i_data_gate (
      .clk            (clk),
      .rst_n          (rst_n),
      .priv_i         (priv_i),
      .access_ok_i    (access_ok),
      .data_req_i     (data_req_i),
      .data_gnt_i     (data_gnt_i),
      .data_err_ack_i (data_err_ack_i),
      .data_req_o     (data_req_o),
      .data_gnt_o     (data_gnt_o),
      .data_err_o     (data_err_o)
   );

   assign data_addr_o = data_addr_i;

endmodule

// File: include/pmp_tb_model.svh
// reference model for the PMP testbench; include inside a module after pmp_pkg is compiled
`ifndef PMP_TB_MODEL_SVH
`define PMP_TB_MODEL_SVH

// length of the run of ones from bit 0 of a rule word
function automatic int unsigned model_ones(pmp_pkg::word_addr_t word);
   int unsigned n;
   n = 0;
   while (n < $bits(pmp_pkg::word_addr_t) && word[n])
   begin
      n++;
   end
   return n;
endfunction

// rule word for a NAPOT region of 2**size_log2 bytes, size_log2 of 3 or more
function automatic pmp_pkg::addr_t model_napot_rule(pmp_pkg::addr_t base, int unsigned size_log2);
   pmp_pkg::addr_t ones;
   ones = (pmp_pkg::addr_t'(1) << (size_log2 - 3)) - 1;
   return (base >> pmp_pkg::word_lsb) | ones;
endfunction

// whether a single entry permits the access, worked out on byte ranges
function automatic bit model_entry_permit(pmp_pkg::pmp_cfg_t cfg, pmp_pkg::addr_t rule,
                                          pmp_pkg::addr_t prev_rule, pmp_pkg::addr_t addr,
                                          bit we, int unsigned max_ones);
   longint unsigned base;
   longint unsigned prev_base;
   longint unsigned size;
   int unsigned     ones;
   bit              hit;
   base      = {32'd0, pmp_pkg::word_addr_t'(rule), 2'b00};
   prev_base = {32'd0, pmp_pkg::word_addr_t'(prev_rule), 2'b00};
   ones      = model_ones(pmp_pkg::word_addr_t'(rule));
   size      = 64'd8 << ones;
   case (cfg.mode)
      pmp_pkg::mode_tor:   hit = (addr >= prev_base) && (addr < base);
      pmp_pkg::mode_na4:   hit = (addr >= base) && (addr < base + 4);
      pmp_pkg::mode_napot: hit = (ones < max_ones) && ((addr & ~(size - 1)) == (base & ~(size - 1)));
      default:             hit = 1'b0;
   endcase
   return hit && (we ? cfg.w : cfg.r);
endfunction

`endif

// File: test/pmp_tb.sv
// directed tests for pmp_top at its default parameters; random NAPOT accesses use a fixed seed
`timescale 1ns/1ps

module pmp_tb;

   localparam int unsigned n_entries       = 16;
   localparam int unsigned napot_max_ones  = 16;
   localparam int unsigned clk_period      = 10;
   localparam int unsigned reset_cycles    = 3;
   localparam int unsigned random_accesses = 24;
   // directed tests take under 60 cycles plus one cycle per random access
   localparam int unsigned test_cycles     = reset_cycles + random_accesses + 60;

   logic                              clk;
   logic                              rst_n;
   pmp_pkg::priv_lvl_e                priv;
   pmp_pkg::pmp_cfg_t [n_entries-1:0] cfg;
   pmp_pkg::addr_t    [n_entries-1:0] rule;
   logic                              data_req;
   pmp_pkg::addr_t                    data_addr;
   logic                              data_we;
   logic                              data_gnt;
   logic                              mem_req;
   pmp_pkg::addr_t                    mem_addr;
   logic                              mem_gnt;
   logic                              data_err;
   logic                              data_err_ack;

   int unsigned errors;
   int unsigned checks;
   int unsigned test_start_errors;
   string       test_name;
   logic [31:0] rng_state;

   `include "pmp_tb_model.svh"

   pmp_top i_dut (
      .clk            (clk),
      .rst_n          (rst_n),
      .priv_i         (priv),
      .pmp_cfg_i      (cfg),
      .pmp_addr_i     (rule),
      .data_req_i     (data_req),
      .data_addr_i    (data_addr),
      .data_we_i      (data_we),
      .data_gnt_o     (data_gnt),
      .data_req_o     (mem_req),
      .data_addr_o    (mem_addr),
      .data_gnt_i     (mem_gnt),
      .data_err_o     (data_err),
      .data_err_ack_i (data_err_ack)
   );

   always #(clk_period / 2) clk = ~clk;

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] next_random();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic pmp_pkg::pmp_cfg_t make_cfg(pmp_pkg::pmp_mode_e mode, bit r, bit w);
      pmp_pkg::pmp_cfg_t c;
      c      = '0;
      c.mode = mode;
      c.r    = r;
      c.w    = w;
      return c;
   endfunction

   // any entry of the table is enough
   function automatic bit model_permit(pmp_pkg::addr_t addr, bit we);
      bit             ok;
      pmp_pkg::addr_t prev;
      ok = 1'b0;
      for (int i = 0; i < n_entries; i++)
      begin
         if (i == 0)
         begin
            prev = '0;
         end
         else
         begin
            prev = rule[i-1];
         end
         ok = ok | model_entry_permit(cfg[i], rule[i], prev, addr, we, napot_max_ones);
      end
      return ok;
   endfunction

   task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
      checks++;
      if (actual !== expected)
      begin
         $display("Mismatch in %s (%s): expected %0h, actual %0h",
                  test_name, what, expected, actual);
         errors++;
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic clear_table();
      cfg  = '0;
      rule = '0;
   endtask

   task automatic clear_error();
      data_req     = 1'b0;
      data_err_ack = 1'b1;
      next_cycle();
      data_err_ack = 1'b0;
      check_value("err cleared", 32'd0, 32'(data_err));
   endtask

   task automatic begin_test(string name);
      test_name         = name;
      test_start_errors = errors;
   endtask

   task automatic end_test();
      if (errors == test_start_errors)
      begin
         $display("%-12s ok", test_name);
      end
      else
      begin
         $display("%-12s failed with %0d errors", test_name, errors - test_start_errors);
      end
   endtask

   // one access per cycle with outputs sampled mid cycle
   task automatic access_check(string what, pmp_pkg::addr_t addr, bit we, bit exp_ok);
      data_req  = 1'b1;
      data_addr = addr;
      data_we   = we;
      mem_gnt   = 1'b1;
      #4;
      check_value({what, " req"}, 32'(exp_ok), 32'(mem_req));
      check_value({what, " gnt"}, 32'(exp_ok), 32'(data_gnt));
      next_cycle();
      data_req = 1'b0;
      mem_gnt  = 1'b0;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic test_machine_bypass();
      pmp_pkg::addr_t a;
      begin_test("machine");
      check_value("err after reset", 32'd0, 32'(data_err));
      clear_table();
      priv = pmp_pkg::priv_m;
      access_check("read", 32'h1234_5678, 1'b0, 1'b1);
      access_check("write", next_random(), 1'b1, 1'b1);
      // request without grant, then grant without request
      a         = next_random();
      data_req  = 1'b1;
      data_addr = a;
      mem_gnt   = 1'b0;
      #4;
      check_value("req only", 32'd1, 32'(mem_req));
      check_value("no gnt", 32'd0, 32'(data_gnt));
      check_value("addr", a, mem_addr);
      next_cycle();
      data_req = 1'b0;
      mem_gnt  = 1'b1;
      #4;
      check_value("no req", 32'd0, 32'(mem_req));
      check_value("gnt only", 32'd1, 32'(data_gnt));
      next_cycle();
      mem_gnt = 1'b0;
      end_test();
   endtask

   task automatic test_na4();
      begin_test("na4");
      clear_table();
      priv    = pmp_pkg::priv_u;
      cfg[3]  = make_cfg(pmp_pkg::mode_na4, 1'b1, 1'b0);
      rule[3] = 32'h1000_0040 >> 2;
      access_check("exact word", 32'h1000_0040, 1'b0, 1'b1);
      access_check("last byte", 32'h1000_0043, 1'b0, 1'b1);
      access_check("next word", 32'h1000_0044, 1'b0, 1'b0);
      clear_error();
      end_test();
   endtask

   task automatic test_tor();
      begin_test("tor");
      clear_table();
      priv    = pmp_pkg::priv_u;
      cfg[0]  = make_cfg(pmp_pkg::mode_tor, 1'b1, 1'b1);
      rule[0] = 32'h0000_2000 >> 2;
      cfg[1]  = make_cfg(pmp_pkg::mode_tor, 1'b1, 1'b1);
      rule[1] = 32'h0000_3000 >> 2;
      access_check("entry 0 low", 32'h0000_0000, 1'b0, 1'b1);
      access_check("entry 0 top", 32'h0000_1ffc, 1'b1, 1'b1);
      access_check("entry 1 low", 32'h0000_2000, 1'b0, 1'b1);
      access_check("entry 1 top", 32'h0000_2ffc, 1'b1, 1'b1);
      access_check("entry 1 bound", 32'h0000_3000, 1'b0, 1'b0);
      clear_error();
      end_test();
   endtask

   task automatic test_napot();
      pmp_pkg::addr_t bases [4];
      pmp_pkg::addr_t spans [4];
      pmp_pkg::addr_t a;
      int unsigned    sel;
      bit             we;
      begin_test("napot");
      clear_table();
      priv     = pmp_pkg::priv_u;
      bases[0] = 32'h4000_0000;
      bases[1] = 32'h4001_0000;
      bases[2] = 32'h4010_0000;
      bases[3] = 32'h5000_0000;
      // sizes 8 B, 4 KiB, 64 KiB and 256 KiB with addresses spread over four times each
      spans[0] = 32'h0000_0020;
      spans[1] = 32'h0000_4000;
      spans[2] = 32'h0004_0000;
      spans[3] = 32'h0010_0000;
      cfg[0]   = make_cfg(pmp_pkg::mode_napot, 1'b1, 1'b0);
      rule[0]  = model_napot_rule(bases[0], 3);
      cfg[1]   = make_cfg(pmp_pkg::mode_napot, 1'b1, 1'b1);
      rule[1]  = model_napot_rule(bases[1], 12);
      cfg[2]   = make_cfg(pmp_pkg::mode_napot, 1'b1, 1'b0);
      rule[2]  = model_napot_rule(bases[2], 16);
      cfg[3]   = make_cfg(pmp_pkg::mode_napot, 1'b0, 1'b1);
      rule[3]  = model_napot_rule(bases[3], 18);
      for (int n = 0; n < random_accesses; n++)
      begin
         sel = next_random() % 4;
         we  = 1'(next_random());
         a   = bases[sel] + (next_random() & (spans[sel] - 1));
         access_check("random", a, we, model_permit(a, we));
      end
      // one trailing one short of the limit is still a region
      clear_table();
      cfg[0]  = make_cfg(pmp_pkg::mode_napot, 1'b1, 1'b1);
      rule[0] = 32'h0000_7fff;
      access_check("below limit", 32'h0000_0100, 1'b0, 1'b1);
      rule[0] = 32'h0000_ffff;
      access_check("at limit read", 32'h0000_0100, 1'b0, 1'b0);
      access_check("at limit write", 32'h0000_0000, 1'b1, 1'b0);
      clear_error();
      end_test();
   endtask

   task automatic test_permissions();
      begin_test("permissions");
      clear_table();
      priv    = pmp_pkg::priv_u;
      cfg[0]  = make_cfg(pmp_pkg::mode_na4, 1'b1, 1'b0);
      rule[0] = 32'h6000_0000 >> 2;
      access_check("write r only", 32'h6000_0000, 1'b1, 1'b0);
      access_check("read r only", 32'h6000_0000, 1'b0, 1'b1);
      // a second, write only region over the same word
      cfg[5]  = make_cfg(pmp_pkg::mode_napot, 1'b0, 1'b1);
      rule[5] = model_napot_rule(32'h6000_0000, 12);
      access_check("mixed write", 32'h6000_0000, 1'b1, 1'b1);
      access_check("mixed read", 32'h6000_0000, 1'b0, 1'b1);
      access_check("w only write", 32'h6000_0010, 1'b1, 1'b1);
      access_check("w only read", 32'h6000_0010, 1'b0, 1'b0);
      clear_error();
      end_test();
   endtask

   task automatic test_error_handshake();
      begin_test("error");
      clear_table();
      priv = pmp_pkg::priv_u;
      check_value("idle", 32'd0, 32'(data_err));
      access_check("first deny", 32'h0000_0100, 1'b0, 1'b0);
      for (int c = 0; c < 4; c++)
      begin
         check_value("err held", 32'd1, 32'(data_err));
         access_check("deny again", 32'h0000_0200, 1'b1, 1'b0);
      end
      check_value("err before ack", 32'd1, 32'(data_err));
      data_err_ack = 1'b1;
      #4;
      check_value("err in ack cycle", 32'd1, 32'(data_err));
      next_cycle();
      data_err_ack = 1'b0;
      check_value("err after ack", 32'd0, 32'(data_err));
      next_cycle();
      check_value("err stays low", 32'd0, 32'(data_err));
      end_test();
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // run
   ////////////////////////////////////////////////////////////////////////////

   initial
   begin
      #(test_cycles * 4 * clk_period);
      $display("watchdog expired before the tests finished");
      $display("TESTS FAILED");
      $finish;
   end

   initial
   begin
      clk          = 1'b0;
      rst_n        = 1'b0;
      priv         = pmp_pkg::priv_m;
      cfg          = '0;
      rule         = '0;
      data_req     = 1'b0;
      data_addr    = '0;
      data_we      = 1'b0;
      mem_gnt      = 1'b0;
      data_err_ack = 1'b0;
      errors       = 0;
      checks       = 0;
      rng_state    = 32'hd8d9;
      repeat (reset_cycles) @(posedge clk);
      #1;
      rst_n = 1'b1;

      test_machine_bypass();
      test_na4();
      test_tor();
      test_napot();
      test_permissions();
      test_error_handshake();

      $display("%0d checks, %0d errors", checks, errors);
      if (errors == 0)
      begin
         $display("TESTS PASSED");
      end
      else
      begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: all.f
+incdir+include
rtl/pmp_pkg.sv
rtl/pmp_rule_decode.sv
rtl/pmp_region_match.sv
rtl/pmp_data_gate.sv
rtl/pmp_top.sv
test/pmp_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = pmp_tb
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

# the run passes only if the pass message shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)
